// File: logic/calc_macros.svh
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// cycles a row must read low before the key counts as pressed
`define CALC_DEBOUNCE_CYCLES 10

// width of operands, accumulator and result
`define CALC_OPERAND_BITS 16

// decimal digits on the display, enough for 32768
`define CALC_BCD_DIGITS 5

`endif

// File: logic/calc_pkg.sv
`include "calc_macros.svh"
`default_nettype none

package calc_pkg;

    typedef logic [3:0] key_index_t;                       // row * 4 + col
    typedef logic [3:0] digit_t;                           // 0 to 9 only

    typedef enum logic [2:0] {
        OP_NONE   = 3'd0,                                  // token is a digit or equals
        OP_NEGATE = 3'd1,                                  // key F, sign toggle
        OP_ADD    = 3'd2,                                  // key 3
        OP_SUB    = 3'd3,                                  // key 7
        OP_MUL    = 3'd4                                   // key B
    } op_t;

    typedef logic signed [`CALC_OPERAND_BITS-1:0] operand_t;   // two's complement, wraps
    typedef logic [4*`CALC_BCD_DIGITS-1:0] bcd_t;              // lsd in low nibble

    typedef enum logic [2:0] {
        IDLE,
        SCAN_COL,
        WAIT_STABLE,
        CONFIRM,
        WAIT_RELEASE
    } scan_state_t;

endpackage

`default_nettype wire

// File: logic/key_token_if.sv
`default_nettype none

interface key_token_if;
    import calc_pkg::*;

    logic   ready;                                         // token held and valid
    digit_t digit;                                         // meaningful when op none, no equal
    op_t    op;                                            // operator or sign toggle
    logic   equal;                                         // equals key
    logic   taken;                                         // one-cycle ack from engine

    modport scanner (
        output ready, digit, op, equal,
        input  taken
    );

    modport engine (
        input  ready, digit, op, equal,
        output taken
    );

endinterface

`default_nettype wire

// File: logic/keypad_scanner.sv
`include "calc_macros.svh"
`default_nettype none

module keypad_scanner (
    input  logic        clk,
    input  logic        nRST,
    input  logic [3:0]  row_in,                            // pulled up, low when pressed
    output logic [3:0]  col_out,                           // one column driven low
    key_token_if.scanner tok
);
    import calc_pkg::*;

    localparam int DB_W = $clog2(`CALC_DEBOUNCE_CYCLES + 1);

    scan_state_t     state;
    scan_state_t     state_next;
    logic [3:0]      row_meta;                             // first sync stage
    logic [3:0]      row_sync;                             // second sync stage
    logic            key_down;                             // some row reads low
    logic [1:0]      col_index;                            // column driven now
    logic [1:0]      col_dly;                              // column one cycle back
    logic [1:0]      col_seen;                             // column that row_sync belongs to
    logic [DB_W-1:0] db_cnt;
    logic            db_done;
    logic [1:0]      row_hit;
    key_index_t      key_now;
    logic            key_empty;
    digit_t          dec_digit;
    op_t             dec_op;
    logic            dec_equal;

    assign col_out   = ~(4'b0001 << col_index);            // 1110 after reset
    assign key_down  = ~&row_sync;
    assign db_done   = key_down && (db_cnt == DB_W'(`CALC_DEBOUNCE_CYCLES - 1));
    assign key_empty = (key_now == 4'd14);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_meta <= 4'hF;                              // idle rows read high
            row_sync <= 4'hF;
        end else begin
            row_meta <= row_in;
            row_sync <= row_meta;
        end
    end

    // lowest pressed row wins, column is the aligned one in WAIT_STABLE
    always_comb begin
        row_hit = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row_sync[r])
                row_hit = 2'(r);
        end
        key_now = {row_hit, col_index};
    end

    always_comb begin
        dec_digit = 4'd0;
        dec_op    = OP_NONE;
        dec_equal = 1'b0;
        case (key_now)
            4'd0:  dec_digit = 4'd1;
            4'd1:  dec_digit = 4'd2;
            4'd2:  dec_digit = 4'd3;
            4'd3:  dec_op    = OP_ADD;
            4'd4:  dec_digit = 4'd4;
            4'd5:  dec_digit = 4'd5;
            4'd6:  dec_digit = 4'd6;
            4'd7:  dec_op    = OP_SUB;
            4'd8:  dec_digit = 4'd7;
            4'd9:  dec_digit = 4'd8;
            4'd10: dec_digit = 4'd9;
            4'd11: dec_op    = OP_MUL;
            4'd12: dec_equal = 1'b1;
            4'd13: dec_digit = 4'd0;
            4'd15: dec_op    = OP_NEGATE;               // minus symbol key
            default: ;                                     // key 14, no token
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:         state_next = SCAN_COL;
            SCAN_COL:     state_next = key_down ? WAIT_STABLE : SCAN_COL;
            WAIT_STABLE: begin
                if (db_done)
                    state_next = key_empty ? WAIT_RELEASE : CONFIRM;
            end
            CONFIRM:      state_next = tok.taken ? WAIT_RELEASE : CONFIRM;
            WAIT_RELEASE: state_next = key_down ? WAIT_RELEASE : IDLE;
            default:      state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            col_index <= 2'd0;
            col_dly   <= 2'd0;
            col_seen  <= 2'd0;
            db_cnt    <= '0;
            tok.ready <= 1'b0;
        end else begin
            state    <= state_next;
            col_dly  <= col_index;
            col_seen <= col_dly;                           // rows lag the column by both sync flops
            case (state)
                SCAN_COL: begin
                    db_cnt <= '0;
                    if (key_down)
                        col_index <= col_seen;             // rewind to the column that hit
                    else
                        col_index <= col_index + 2'd1;
                end
                WAIT_STABLE: begin
                    if (!key_down)
                        db_cnt <= '0;                      // bounce gap, start over
                    else if (!db_done)
                        db_cnt <= db_cnt + 1'b1;
                    if (db_done && !key_empty)
                        tok.ready <= 1'b1;                 // high from first CONFIRM cycle
                end
                CONFIRM: begin
                    if (tok.taken)
                        tok.ready <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    // token held steady for the whole of CONFIRM
    always_ff @(posedge clk) begin
        if (state == WAIT_STABLE && db_done) begin
            tok.digit <= dec_digit;
            tok.op    <= dec_op;
            tok.equal <= dec_equal;
        end
    end

endmodule

`default_nettype wire

// File: logic/calc_engine.sv
`default_nettype none

module calc_engine (
    input  logic               clk,
    input  logic               nRST,
    key_token_if.engine        tok,
    output calc_pkg::operand_t result,
    output logic               result_strobe
);
    import calc_pkg::*;

    operand_t acc;                                         // running left-to-right value
    operand_t entry_mag;                                   // digits typed so far
    logic     entry_neg;                                   // sign toggled by key F
    op_t      pending_op;                                  // applied at next operator or equals
    operand_t entry_val;
    operand_t eval_val;
    logic     is_digit;

    assign entry_val = entry_neg ? -entry_mag : entry_mag;
    assign is_digit  = (tok.op == OP_NONE) && !tok.equal;

    always_comb begin
        case (pending_op)
            OP_SUB:  eval_val = acc - entry_val;
            OP_MUL:  eval_val = acc * entry_val;           // low 16 bits kept
            default: eval_val = acc + entry_val;
        endcase
    end

    // ack one cycle after ready, once per token
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            tok.taken <= 1'b0;
        else
            tok.taken <= tok.ready && !tok.taken;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            acc           <= '0;
            entry_mag     <= '0;
            entry_neg     <= 1'b0;
            pending_op    <= OP_ADD;
            result_strobe <= 1'b0;
        end else begin
            result_strobe <= 1'b0;
            if (tok.taken) begin
                if (tok.equal) begin
                    acc           <= '0;
                    entry_mag     <= '0;
                    entry_neg     <= 1'b0;
                    pending_op    <= OP_ADD;
                    result_strobe <= 1'b1;
                end else if (is_digit) begin
                    entry_mag <= operand_t'(entry_mag * 10 + tok.digit);   // wraps
                end else if (tok.op == OP_NEGATE) begin
                    entry_neg <= !entry_neg;
                end else begin
                    acc        <= eval_val;                // no precedence
                    pending_op <= tok.op;
                    entry_mag  <= '0;
                    entry_neg  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tok.taken && tok.equal)
            result <= eval_val;                            // valid with result_strobe
    end

endmodule

`default_nettype wire

// File: logic/result_display.sv
`include "calc_macros.svh"
`default_nettype none

module result_display (
    input  logic               clk,
    input  logic               nRST,
    input  calc_pkg::operand_t result,
    input  logic               result_strobe,
    output logic               shown_negative,
    output calc_pkg::bcd_t     shown_digits,
    output logic               shown_valid
);
    import calc_pkg::*;

    localparam int STEP_W = $clog2(`CALC_OPERAND_BITS);

    logic                          busy;                   // conversion running
    logic [STEP_W-1:0]             step;                   // shift steps done
    logic                          last_step;
    logic                          neg_hold;               // sign of latched result
    logic [`CALC_OPERAND_BITS-1:0] bin_work;               // magnitude, msb shifts out
    bcd_t                          bcd_work;
    bcd_t                          bcd_adj;
    bcd_t                          bcd_next;

    assign last_step = (step == STEP_W'(`CALC_OPERAND_BITS - 1));

    // add 3 to nibbles of 5 or more, then shift in next binary bit
    always_comb begin
        bcd_adj = bcd_work;
        for (int i = 0; i < `CALC_BCD_DIGITS; i++) begin
            if (bcd_work[4*i +: 4] >= 4'd5)
                bcd_adj[4*i +: 4] = bcd_work[4*i +: 4] + 4'd3;
        end
        bcd_next = {bcd_adj[4*`CALC_BCD_DIGITS-2:0], bin_work[`CALC_OPERAND_BITS-1]};
    end

    always_ff @(posedge clk) begin
        if (result_strobe && !busy) begin
            neg_hold <= result[`CALC_OPERAND_BITS-1];
            bin_work <= result[`CALC_OPERAND_BITS-1] ? -result : result;   // -32768 gives 32768
            bcd_work <= '0;
        end else if (busy) begin
            bcd_work <= bcd_next;
            bin_work <= bin_work << 1;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy           <= 1'b0;
            step           <= '0;
            shown_valid    <= 1'b0;
            shown_negative <= 1'b0;
            shown_digits   <= '0;
        end else begin
            shown_valid <= 1'b0;
            if (result_strobe && !busy) begin              // strobe while busy is dropped
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin                       // 16th shift, outputs load now
                    busy           <= 1'b0;
                    shown_valid    <= 1'b1;
                    shown_negative <= neg_hold;
                    shown_digits   <= bcd_next;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/keypad_calc_top.sv
`default_nettype none

module keypad_calc_top (
    input  logic           clk,
    input  logic           nRST,
    input  logic [3:0]     row_in,                         // keypad rows, pulled up
    output logic [3:0]     col_out,                        // keypad columns, one low
    output logic           shown_negative,
    output calc_pkg::bcd_t shown_digits,
    output logic           shown_valid
);
    import calc_pkg::*;

    operand_t result;                                      // engine to display
    logic     result_strobe;

    key_token_if tok_bus ();                               // scanner to engine tokens

    keypad_scanner u_scanner (
        .clk     (clk),
        .nRST    (nRST),
        .row_in  (row_in),
        .col_out (col_out),
        .tok     (tok_bus.scanner)
    );

    calc_engine u_engine (
        .clk           (clk),
        .nRST          (nRST),
        .tok           (tok_bus.engine),
        .result        (result),
        .result_strobe (result_strobe)
    );

    result_display u_display (
        .clk            (clk),
        .nRST           (nRST),
        .result         (result),
        .result_strobe  (result_strobe),
        .shown_negative (shown_negative),
        .shown_digits   (shown_digits),
        .shown_valid    (shown_valid)
    );

endmodule

`default_nettype wire

// File: tests/calc_checker.sv
`default_nettype none

module calc_checker (
    input logic                  clk,
    input logic                  nRST,
    input calc_pkg::scan_state_t state,
    input logic                  ready,
    input logic                  taken,
    input logic [3:0]            col_out,
    input logic                  shown_valid
);
    timeunit 1ns;
    timeprecision 100ps;
    import calc_pkg::*;

    int fail_count = 0;                                    // read by the testbench

    ready_drops_after_taken: assert property (@(posedge clk) disable iff (!nRST)
        taken |=> !ready)
        else begin $error("ready still high the cycle after taken"); fail_count++; end

    taken_needs_ready: assert property (@(posedge clk) disable iff (!nRST)
        taken |-> ready)
        else begin $error("taken pulsed while ready was low"); fail_count++; end

    ready_only_in_confirm: assert property (@(posedge clk) disable iff (!nRST)
        ready == (state == CONFIRM))
        else begin $error("ready out of step with CONFIRM state"); fail_count++; end

    one_column_low: assert property (@(posedge clk) disable iff (!nRST)
        $onehot(~col_out))
        else begin $error("col_out does not have exactly one column low"); fail_count++; end

    valid_single_pulse: assert property (@(posedge clk) disable iff (!nRST)
        shown_valid |=> !shown_valid)
        else begin $error("shown_valid high for more than one cycle"); fail_count++; end

endmodule

// scanner state reached through the top, token bus through its interface
bind keypad_calc_top calc_checker u_chk (
    .clk         (clk),
    .nRST        (nRST),
    .state       (u_scanner.state),
    .ready       (tok_bus.ready),
    .taken       (tok_bus.taken),
    .col_out     (col_out),
    .shown_valid (shown_valid)
);

`default_nettype wire

// File: tests/calc_monitor.sv
`default_nettype none

module calc_monitor (
    input logic           clk,
    input logic           nRST,
    input logic [3:0]     col_out,
    input logic           shown_negative,
    input calc_pkg::bcd_t shown_digits,
    input logic           shown_valid
);
    timeunit 1ns;
    timeprecision 100ps;
    import calc_pkg::*;

    logic exp_neg_q[$];                                    // expected sign per equals
    bcd_t exp_digits_q[$];                                 // expected digits per equals
    logic exp_neg;
    bcd_t exp_digits;
    int   mismatch_count = 0;
    int   missing_count  = 0;
    int   extra_count    = 0;
    int   run_cycles     = 0;                              // rising edges since reset release

    task automatic expect_result(input logic neg, input bcd_t digits);
        exp_neg_q.push_back(neg);
        exp_digits_q.push_back(digits);
    endtask

    function automatic int pending();
        return exp_neg_q.size();
    endfunction

    task automatic report_leftovers();
        if (exp_neg_q.size() != 0) begin
            $display("%0d expected results were never shown", exp_neg_q.size());
            missing_count += exp_neg_q.size();
            exp_neg_q.delete();
            exp_digits_q.delete();
        end
    endtask

    always @(posedge clk) begin
        if (!nRST)
            run_cycles <= 0;
        else if (run_cycles < 2)
            run_cycles <= run_cycles + 1;
    end

    // sampled mid-cycle, outputs settled since the rising edge
    always @(negedge clk) begin
        if (!nRST || run_cycles == 1) begin                // in reset and first cycle out
            if (col_out !== 4'b1110 || shown_valid !== 1'b0 || shown_negative !== 1'b0
                    || shown_digits !== '0) begin
                $display("** Error @ %0t: reset state col_out %b valid %b neg %b digits %05h",
                         $time, col_out, shown_valid, shown_negative, shown_digits);
                mismatch_count++;
            end
        end else if (shown_valid === 1'b1) begin
            if (exp_neg_q.size() == 0) begin
                $display("a result was shown with no expected value left: %s%05h",
                         shown_negative ? "-" : "+", shown_digits);
                extra_count++;
            end else begin
                exp_neg    = exp_neg_q.pop_front();
                exp_digits = exp_digits_q.pop_front();
                if (shown_negative !== exp_neg || shown_digits !== exp_digits) begin
                    $display("** Error @ %0t: expected %s%05h, shown %s%05h", $time,
                             exp_neg ? "-" : "+", exp_digits,
                             shown_negative ? "-" : "+", shown_digits);
                    mismatch_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/keypad_calc_tb.sv
`default_nettype none

module keypad_calc_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import calc_pkg::*;

    logic       clk    = 1'b0;
    logic       nRST   = 1'b0;                             // low from time zero
    logic [3:0] row_in = 4'hF;                             // no key pressed
    logic [3:0] col_out;
    logic       shown_negative;
    bcd_t       shown_digits;
    logic       shown_valid;

    int press_key[$];                                      // key index per press
    int press_hold[$];                                     // cycles held down
    int press_rel[$];                                      // cycles released after
    int total_cycles = 0;                                  // sum of hold and release
    int pressed      = -1;                                 // key held now, -1 for none
    int load_errors  = 0;
    bit loaded       = 1'b0;
    bit timed_out    = 1'b0;

    keypad_calc_top dut (
        .clk            (clk),
        .nRST           (nRST),
        .row_in         (row_in),
        .col_out        (col_out),
        .shown_negative (shown_negative),
        .shown_digits   (shown_digits),
        .shown_valid    (shown_valid)
    );

    calc_monitor mon (
        .clk            (clk),
        .nRST           (nRST),
        .col_out        (col_out),
        .shown_negative (shown_negative),
        .shown_digits   (shown_digits),
        .shown_valid    (shown_valid)
    );

    always #5 clk = ~clk;                                  // 10 ns period

    // keypad matrix, row r pulled low only while column c is driven low
    always @(negedge clk) begin
        if (pressed >= 0 && !col_out[pressed % 4])
            row_in <= ~(4'b0001 << (pressed / 4));
        else
            row_in <= 4'hF;
    end

    // p lines are presses, r lines expected results, # lines skipped
    task automatic load_testdata();
        int    fd;
        int    n;
        int    key;
        int    hold;
        int    rel;
        int    sgn;
        bcd_t  digits;
        string tag;
        string line;
        fd = $fopen("tests/keypad_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/keypad_testdata.txt");
            load_errors++;
            return;
        end
        while ($fscanf(fd, " %s", tag) == 1) begin
            if (tag == "p") begin
                n = $fscanf(fd, " %d %d %d", key, hold, rel);
                if (n != 3)
                    load_errors++;
                press_key.push_back(key);
                press_hold.push_back(hold);
                press_rel.push_back(rel);
                total_cycles += hold + rel;
            end else if (tag == "r") begin
                n = $fscanf(fd, " %d %h", sgn, digits);
                if (n != 2)
                    load_errors++;
                mon.expect_result(sgn[0], digits);         // handed over in file order
            end else begin
                n = $fgets(line, fd);                      // comment, rest of line
            end
        end
        $fclose(fd);
        if (load_errors != 0)
            $display("malformed lines in tests/keypad_testdata.txt: %0d", load_errors);
    endtask

    task automatic finish_run();
        int total;
        mon.report_leftovers();
        total = mon.mismatch_count + mon.missing_count + mon.extra_count
              + dut.u_chk.fail_count + load_errors + int'(timed_out);
        $display("errors: %0d mismatch, %0d missing, %0d unexpected, %0d assertion, %0d load, %0d timeout",
                 mon.mismatch_count, mon.missing_count, mon.extra_count,
                 dut.u_chk.fail_count, load_errors, int'(timed_out));
        if (total == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    endtask

    initial begin
        load_testdata();
        loaded = 1'b1;
        repeat (5) @(negedge clk);                         // 5 rising edges in reset
        nRST <= 1'b1;
        foreach (press_key[i]) begin
            pressed <= press_key[i];                       // nba, keypad model sees it next edge
            repeat (press_hold[i]) @(negedge clk);
            pressed <= -1;
            repeat (press_rel[i]) @(negedge clk);
        end
        while (mon.pending() != 0)                         // last result still converting
            @(negedge clk);
        finish_run();
    end

    // presses plus reset plus 200 cycles of slack
    initial begin
        wait (loaded);
        #((total_cycles + 205) * 10);
        timed_out = 1'b1;
        $display("watchdog expired after %0d cycles, results still outstanding: %0d",
                 total_cycles + 205, mon.pending());
        finish_run();
    end

endmodule

`default_nettype wire

// File: tests/keypad_testdata.txt
# p <key index> <hold cycles> <release cycles>
# r <negative 0/1> <five bcd digits, hex>
# 123 =
p 0 40 20
p 1 40 20
p 2 40 20
p 12 40 40
r 0 00123
# 7 + 5 * 3 =
p 8 40 20
p 3 40 20
p 5 40 20
p 11 40 20
p 2 40 20
p 12 40 40
r 0 00036
# 9 - 20 =
p 10 40 20
p 7 40 20
p 1 40 20
p 13 40 20
p 12 40 40
r 1 00011
# neg 8 * 4 =
p 15 40 20
p 9 40 20
p 11 40 20
p 4 40 20
p 12 40 40
r 1 00032
# 300 * 300 = wraps 90000 to 24464
p 2 40 20
p 13 40 20
p 13 40 20
p 11 40 20
p 2 40 20
p 13 40 20
p 13 40 20
p 12 40 40
r 0 24464
# 5, empty key, 6 held long, + 2 =
p 5 40 20
p 14 40 20
p 6 300 20
p 3 40 20
p 1 40 20
p 12 40 40
r 0 00058

// File: compile.f
+incdir+logic
logic/calc_pkg.sv
logic/key_token_if.sv
logic/keypad_scanner.sv
logic/calc_engine.sv
logic/result_display.sv
logic/keypad_calc_top.sv
tests/calc_checker.sv
tests/calc_monitor.sv
tests/keypad_calc_tb.sv

// File: Bender.yml
package:
  name: keypad_calc

sources:
  - include_dirs:
      - logic
    files:
      - logic/calc_pkg.sv
      - logic/key_token_if.sv
      - logic/keypad_scanner.sv
      - logic/calc_engine.sv
      - logic/result_display.sv
      - logic/keypad_calc_top.sv
  - target: test
    files:
      - tests/calc_checker.sv
      - tests/calc_monitor.sv
      - tests/keypad_calc_tb.sv
